//--- owm_master.f
design/owm_bus_pkg.sv
design/owm_cmd_pkg.sv
design/owm_cmd_intake.sv
design/owm_byte_sequencer.sv
design/owm_slot_engine.sv
design/owm_line_io.sv
design/owm_rsp_stage.sv
design/owm_master.sv
bench/owm_slave_model.sv
bench/owm_master_tb.sv

//--- bench/owm_master_tb.sv
`timescale 1ns/1ps
`default_nettype none

module owm_master_tb;

  localparam int wait_limit  = 4000;
  localparam int quiet_limit = 8 * (owm_bus_pkg::owm_bit_total + owm_bus_pkg::owm_sync_stages + 4);

  logic                   MR;
  logic                   CLK;
  logic                   cmd_valid;
  owm_cmd_pkg::owm_cmd_t  cmd;
  logic                   cmd_ready;
  logic                   rsp_valid;
  owm_cmd_pkg::owm_rsp_t  rsp;
  logic                   rsp_ready;
  logic [7:0]             dq_t;
  logic [7:0]             dq_i;
  logic [7:0][7:0]        pattern;
  logic [7:0][7:0]        wr_byte;
  logic [31:0]            rng;
  owm_cmd_pkg::owm_rsp_t  expected [$];
  int                     stall_cycles;
  logic                   track_line;
  owm_bus_pkg::owm_line_t cur_line;

  owm_master i_owm_master (
    .MR, .CLK, .cmd_valid, .cmd, .cmd_ready, .rsp_valid, .rsp, .rsp_ready, .dq_t, .dq_i
  );

  owm_slave_model i_owm_slave_model (.MR, .CLK, .dq_t, .pattern, .dq_i, .wr_byte);

  initial begin
    MR = 1'b0;
    forever #5 MR = !MR;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic owm_cmd_pkg::owm_cmd_t make_cmd(input owm_cmd_pkg::owm_op_e op,
                                                     input int line, input logic [7:0] data);
    return '{op: op, line: owm_bus_pkg::owm_line_t'(line), data: data};
  endfunction

  function automatic owm_cmd_pkg::owm_cmd_t random_cmd();
    rng = xorshift(rng);
    return make_cmd(owm_cmd_pkg::owm_op_e'(rng[1:0] % 2'd3), int'(rng[10:8]), rng[23:16]);
  endfunction

  // Short slots read back the pattern and an empty line floats high
  function automatic logic [7:0] line_answer(input owm_bus_pkg::owm_line_t line);
    return (line < 3'd6) ? pattern[line] : 8'hff;
  endfunction

  function automatic owm_cmd_pkg::owm_rsp_t predict_rsp(input owm_cmd_pkg::owm_cmd_t c);
    owm_cmd_pkg::owm_rsp_t r;
    r = '{op: c.op, line: c.line, data: 8'h00, presence: 1'b0};
    case (c.op)
      owm_cmd_pkg::owm_op_reset: r.presence = (c.line < 3'd6);
      owm_cmd_pkg::owm_op_write: r.data = c.data & line_answer(c.line); // Write-0 reads low
      default:                   r.data = line_answer(c.line);
    endcase
    return r;
  endfunction

  // Drives one host cycle at the falling edge and handshakes complete at the next rising edge
  task automatic host_cycle(input logic send, input owm_cmd_pkg::owm_cmd_t c,
                            input logic take, output logic sent);
    owm_cmd_pkg::owm_rsp_t exp_rsp;
    @(negedge MR);
    cmd_valid = send;
    cmd       = c;
    rsp_ready = take;
    sent      = send && cmd_ready;
    if (sent) expected.push_back(predict_rsp(c));
    if (take && rsp_valid) begin
      assert (expected.size() > 0)
        else abort_run($sformatf("Unexpected response at %0t: %h", $time, rsp));
      exp_rsp = expected.pop_front();
      assert (rsp == exp_rsp)
        else abort_run($sformatf("Mismatch at %0t: rsp %h, expected %h", $time, rsp, exp_rsp));
    end
  endtask

  task automatic send_cmd(input owm_cmd_pkg::owm_cmd_t c, input logic take);
    logic sent;
    int   n;
    sent = 1'b0;
    n    = 0;
    while (!sent) begin
      host_cycle(1'b1, c, take, sent);
      n++;
      if (n > wait_limit) abort_run($sformatf("Timeout at %0t: command never accepted", $time));
    end
  endtask

  task automatic drain_all();
    logic sent;
    int   n;
    n = 0;
    while (expected.size() > 0) begin
      host_cycle(1'b0, cmd, 1'b1, sent);
      n++;
      if (n > wait_limit) abort_run($sformatf("Timeout at %0t: response never arrived", $time));
    end
  endtask

  task automatic run_one(input owm_cmd_pkg::owm_cmd_t c);
    cur_line = c.line;
    send_cmd(c, 1'b1);
    drain_all();
  endtask

  always_ff @(posedge MR or negedge CLK) begin
    if (!CLK) begin
      stall_cycles <= 0;
    end else if (rsp_valid && !rsp_ready && !cmd_ready) begin
      stall_cycles <= stall_cycles + 1; // Response stage and intake both full
    end else begin
      stall_cycles <= 0;
    end
  end

  assert property (@(posedge MR) disable iff (!CLK) ((~dq_t) & ((~dq_t) - 8'd1)) == 8'd0)
    else abort_run($sformatf("Mismatch at %0t: several lines low, dq_t %b", $time, dq_t));
  assert property (@(posedge MR) disable iff (!CLK)
                   track_line |-> (dq_t | (8'd1 << cur_line)) == 8'hff)
    else abort_run($sformatf("Mismatch at %0t: unselected line low, dq_t %b", $time, dq_t));
  assert property (@(posedge MR) disable iff (!CLK) stall_cycles > quiet_limit |-> dq_t == 8'hff)
    else abort_run($sformatf("Mismatch at %0t: bus active while stalled, dq_t %b", $time, dq_t));
  assert property (@(posedge MR) disable iff (!CLK)
                   rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else abort_run($sformatf("Mismatch at %0t: response changed under back-pressure", $time));

  initial begin
    logic                  sent;
    int                    n;
    int                    accepted;
    owm_cmd_pkg::owm_cmd_t c;
    CLK        = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    rsp_ready  = 1'b0;
    track_line = 1'b0;
    cur_line   = '0;
    rng        = 32'hc1b3_f0c8;
    for (int i = 0; i < 8; i++) begin
      rng        = xorshift(rng);
      pattern[i] = rng[7:0];
    end
    repeat (10) @(negedge MR);
    CLK = 1'b1;
    @(negedge MR);
    assert (dq_t == 8'hff && cmd_ready && !rsp_valid)
      else abort_run($sformatf("Mismatch at %0t: after reset dq_t %b cmd_ready %b rsp_valid %b",
                               $time, dq_t, cmd_ready, rsp_valid));
    track_line = 1'b1;
    for (int l = 0; l < 8; l++) run_one(make_cmd(owm_cmd_pkg::owm_op_reset, l, 8'h00));
    for (int l = 0; l < 8; l++) begin
      rng = xorshift(rng);
      c   = make_cmd(owm_cmd_pkg::owm_op_write, l, rng[15:8]);
      run_one(c);
      if (l < 6) begin
        assert (wr_byte[l] == c.data)
          else abort_run($sformatf("Mismatch at %0t: line %0d got %h, written %h",
                                   $time, l, wr_byte[l], c.data));
      end
    end
    for (int l = 0; l < 8; l++) run_one(make_cmd(owm_cmd_pkg::owm_op_read, l, 8'h00));
    track_line = 1'b0;
    c        = random_cmd();
    n        = 0;
    accepted = 0;
    while (stall_cycles <= quiet_limit + 20) begin
      host_cycle(1'b1, c, 1'b0, sent);
      if (sent) begin
        accepted++;
        c = random_cmd();
      end
      n++;
      if (n > wait_limit) begin
        abort_run($sformatf("Timeout at %0t: cmd_ready never dropped under back-pressure", $time));
      end
    end
    assert (accepted == 3)
      else abort_run($sformatf("Mismatch at %0t: %0d commands accepted while blocked, expected 3",
                               $time, accepted));
    send_cmd(c, 1'b1);
    repeat (3) send_cmd(random_cmd(), 1'b1);
    drain_all();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/owm_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module owm_slave_model (
  input  wire             MR,
  input  wire             CLK,
  input  wire  [7:0]      dq_t,
  input  wire  [7:0][7:0] pattern,
  output logic [7:0]      dq_i,
  output logic [7:0][7:0] wr_byte
);

  localparam logic [7:0] device_mask = 8'h3f; // Lines 6 and 7 are empty
  localparam int reset_min    = owm_bus_pkg::owm_reset_low / 2;
  localparam int bit_pull_end = owm_bus_pkg::owm_bit_sample + 1;
  localparam int pres_start   = owm_bus_pkg::owm_reset_low + 4;
  localparam int pres_end     = owm_bus_pkg::owm_presence_sample + 12;

  logic [7:0]      low_q;
  logic [7:0]      bit_pull_q;
  logic [7:0]      pres_q;
  logic [7:0][2:0] idx_q;
  logic [7:0][7:0] shift_q;
  logic [7:0][9:0] tick_q;
  logic [7:0][7:0] low_len_q;
  logic [7:0]      pull;

  // Tick counts negedges since the master first pulled the line low
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      pull[i] = device_mask[i] &&
                ((bit_pull_q[i] && tick_q[i] <= bit_pull_end) ||
                 (pres_q[i] && tick_q[i] >= pres_start && tick_q[i] < pres_end));
      dq_i[i] = dq_t[i] && !pull[i]; // Wired-AND with the external pull-up
    end
  end

  // Watches the master drive between clock edges where it is stable
  always_ff @(negedge MR or negedge CLK) begin
    if (!CLK) begin
      low_q      <= '0;
      bit_pull_q <= '0;
      pres_q     <= '0;
      idx_q      <= '0;
      shift_q    <= '0;
      tick_q     <= '1;
      low_len_q  <= '0;
      wr_byte    <= '0;
    end else begin
      for (int i = 0; i < 8; i++) begin
        low_q[i] <= !dq_t[i];
        if (!dq_t[i] && !low_q[i]) begin
          tick_q[i]     <= 10'd1;
          low_len_q[i]  <= 8'd1;
          bit_pull_q[i] <= !pattern[i][idx_q[i]]; // A zero pattern bit holds a read slot low
          pres_q[i]     <= 1'b0;
        end else begin
          if (tick_q[i] != '1) tick_q[i] <= tick_q[i] + 10'd1;
          if (!dq_t[i] && low_len_q[i] != '1) low_len_q[i] <= low_len_q[i] + 8'd1;
          if (dq_t[i] && low_q[i]) begin
            if (low_len_q[i] >= reset_min) begin
              pres_q[i] <= 1'b1; // Long low is a reset so answer with presence
              idx_q[i]  <= '0;
            end else begin
              shift_q[i] <= {low_len_q[i] <= owm_bus_pkg::owm_bit_sample, shift_q[i][7:1]};
              idx_q[i]   <= idx_q[i] + 3'd1;
              if (idx_q[i] == 3'd7) begin
                wr_byte[i] <= {low_len_q[i] <= owm_bus_pkg::owm_bit_sample, shift_q[i][7:1]};
              end
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/owm_master.sv
`timescale 1ns/1ps
`default_nettype none

module owm_master (
  input  wire                                   MR,
  input  wire                                   CLK,
  input  wire                                   cmd_valid,
  input  owm_cmd_pkg::owm_cmd_t                 cmd,
  output logic                                  cmd_ready,
  output logic                                  rsp_valid,
  output owm_cmd_pkg::owm_rsp_t                 rsp,
  input  wire                                   rsp_ready,
  output logic [owm_bus_pkg::owm_num_lines-1:0] dq_t,
  input  wire  [owm_bus_pkg::owm_num_lines-1:0] dq_i
);

  logic                       next_valid, next_ready;
  owm_cmd_pkg::owm_cmd_t      next_cmd;
  logic                       slot_valid, slot_ready, slot_done, slot_bit;
  owm_bus_pkg::owm_slot_req_t slot_req;
  owm_bus_pkg::owm_line_t     line_sel;
  logic                       bus_low, line_level;
  logic                       rsp_in_valid, rsp_in_ready;
  owm_cmd_pkg::owm_rsp_t      rsp_in;

  owm_cmd_intake i_owm_cmd_intake (
    .MR, .CLK, .cmd_valid, .cmd, .cmd_ready, .next_valid, .next_cmd, .next_ready
  );

  owm_byte_sequencer i_owm_byte_sequencer (
    .MR, .CLK, .next_valid, .next_cmd, .next_ready, .slot_valid, .slot_req, .slot_ready,
    .slot_done, .slot_bit, .rsp_in_valid, .rsp_in, .rsp_in_ready
  );

  owm_slot_engine i_owm_slot_engine (
    .MR, .CLK, .slot_valid, .slot_req, .slot_ready, .slot_done, .slot_bit, .line_sel,
    .bus_low, .line_level
  );

  owm_line_io i_owm_line_io (
    .MR, .CLK, .line_sel, .bus_low, .dq_i, .dq_t, .line_level
  );

  owm_rsp_stage i_owm_rsp_stage (
    .MR, .CLK, .rsp_in_valid, .rsp_in, .rsp_in_ready, .rsp_valid, .rsp, .rsp_ready
  );

endmodule

`default_nettype wire

//--- design/owm_rsp_stage.sv
`timescale 1ns/1ps
`default_nettype none

module owm_rsp_stage (
  input  wire                   MR,
  input  wire                   CLK,
  input  wire                   rsp_in_valid,
  input  owm_cmd_pkg::owm_rsp_t rsp_in,
  output logic                  rsp_in_ready,
  output logic                  rsp_valid,
  output owm_cmd_pkg::owm_rsp_t rsp,
  input  wire                   rsp_ready
);

  logic                  full_q;
  owm_cmd_pkg::owm_rsp_t word_q;

  assign rsp_in_ready = !full_q || rsp_ready;
  assign rsp_valid    = full_q;
  assign rsp          = word_q;

  always_ff @(posedge MR or negedge CLK) begin
    if (!CLK) begin
      full_q <= 1'b0;
    end else if (rsp_in_valid && rsp_in_ready) begin
      full_q <= 1'b1;
    end else if (rsp_ready) begin
      full_q <= 1'b0; // Word taken by the host
    end
  end

  always_ff @(posedge MR) begin
    if (rsp_in_valid && rsp_in_ready) word_q <= rsp_in;
  end

endmodule

`default_nettype wire

//--- design/owm_line_io.sv
`timescale 1ns/1ps
`default_nettype none

module owm_line_io (
  input  wire                                     MR,
  input  wire                                     CLK,
  input  owm_bus_pkg::owm_line_t                  line_sel,
  input  wire                                     bus_low,
  input  wire  [owm_bus_pkg::owm_num_lines-1:0]   dq_i,
  output logic [owm_bus_pkg::owm_num_lines-1:0]   dq_t,
  output logic                                    line_level
);

  logic [owm_bus_pkg::owm_sync_stages-1:0] sync_q;

  // Only the selected line may be pulled low; the rest float high
  always_comb begin
    for (int i = 0; i < owm_bus_pkg::owm_num_lines; i++) begin
      dq_t[i] = !(bus_low && (line_sel == owm_bus_pkg::owm_line_t'(i)));
    end
  end

  always_ff @(posedge MR or negedge CLK) begin
    if (!CLK) begin
      sync_q <= '1; // Released level
    end else begin
      sync_q <= {sync_q[owm_bus_pkg::owm_sync_stages-2:0], dq_i[line_sel]};
    end
  end

  assign line_level = sync_q[owm_bus_pkg::owm_sync_stages-1];

endmodule

`default_nettype wire

//--- design/owm_slot_engine.sv
`timescale 1ns/1ps
`default_nettype none

module owm_slot_engine (
  input  wire                         MR,
  input  wire                         CLK,
  input  wire                         slot_valid,
  input  owm_bus_pkg::owm_slot_req_t  slot_req,
  output logic                        slot_ready,
  output logic                        slot_done,
  output logic                        slot_bit,
  output owm_bus_pkg::owm_line_t      line_sel,
  output logic                        bus_low,
  input  wire                         line_level
);

  typedef enum logic [1:0] {
    eng_idle,
    eng_active,
    eng_finish
  } eng_state_e;

  eng_state_e             state_q;
  owm_bus_pkg::owm_tick_t cnt_q;
  owm_bus_pkg::owm_slot_e kind_q;
  owm_bus_pkg::owm_line_t line_q;
  logic                   bit_q;
  owm_bus_pkg::owm_tick_t low_len;
  owm_bus_pkg::owm_tick_t sample_pt;
  owm_bus_pkg::owm_tick_t last_pt;

  // Sample and end points include the synchronizer latency
  always_comb begin
    case (kind_q)
      owm_bus_pkg::owm_slot_reset: begin
        low_len   = owm_bus_pkg::owm_reset_low;
        sample_pt = owm_bus_pkg::owm_tick_t'(owm_bus_pkg::owm_presence_sample
                                             + owm_bus_pkg::owm_sync_stages);
        last_pt   = owm_bus_pkg::owm_tick_t'(owm_bus_pkg::owm_reset_total
                                             + owm_bus_pkg::owm_sync_stages - 2);
      end
      default: begin
        low_len   = (kind_q == owm_bus_pkg::owm_slot_write0) ? owm_bus_pkg::owm_write0_low
                                                             : owm_bus_pkg::owm_short_low;
        sample_pt = owm_bus_pkg::owm_tick_t'(owm_bus_pkg::owm_bit_sample
                                             + owm_bus_pkg::owm_sync_stages);
        last_pt   = owm_bus_pkg::owm_tick_t'(owm_bus_pkg::owm_bit_total
                                             + owm_bus_pkg::owm_sync_stages - 2);
      end
    endcase
  end

  assign slot_ready = (state_q == eng_idle);
  assign slot_done  = (state_q == eng_finish);
  assign slot_bit   = bit_q;
  assign line_sel   = line_q;
  assign bus_low    = (state_q == eng_active) && (cnt_q < low_len);

  always_ff @(posedge MR or negedge CLK) begin
    if (!CLK) begin
      state_q <= eng_idle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        eng_idle: if (slot_valid) begin
          state_q <= eng_active;
          cnt_q   <= '0;
        end
        eng_active: begin
          cnt_q <= cnt_q + 8'd1;
          if (cnt_q == last_pt) state_q <= eng_finish; // Finish cycle completes the slot
        end
        default: state_q <= eng_idle;
      endcase
    end
  end

  always_ff @(posedge MR) begin
    if (state_q == eng_idle && slot_valid) begin
      kind_q <= slot_req.kind;
      line_q <= slot_req.line;
    end
    if (state_q == eng_active && cnt_q == sample_pt) begin
      // A low line during a reset slot means a device answered
      bit_q <= (kind_q == owm_bus_pkg::owm_slot_reset) ? !line_level : line_level;
    end
  end

endmodule

`default_nettype wire

//--- design/owm_byte_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module owm_byte_sequencer (
  input  wire                         MR,
  input  wire                         CLK,
  input  wire                         next_valid,
  input  owm_cmd_pkg::owm_cmd_t       next_cmd,
  output logic                        next_ready,
  output logic                        slot_valid,
  output owm_bus_pkg::owm_slot_req_t  slot_req,
  input  wire                         slot_ready,
  input  wire                         slot_done,
  input  wire                         slot_bit,
  output logic                        rsp_in_valid,
  output owm_cmd_pkg::owm_rsp_t       rsp_in,
  input  wire                         rsp_in_ready
);

  typedef enum logic [1:0] {
    seq_idle,
    seq_request,
    seq_wait,
    seq_respond
  } seq_state_e;

  seq_state_e             state_q;
  logic [2:0]             bit_cnt_q;
  owm_cmd_pkg::owm_op_e   op_q;
  owm_bus_pkg::owm_line_t line_q;
  owm_cmd_pkg::owm_byte_t shift_q;
  logic                   presence_q;

  assign next_ready   = (state_q == seq_idle);
  assign slot_valid   = (state_q == seq_request);
  assign rsp_in_valid = (state_q == seq_respond);

  always_comb begin
    slot_req.line = line_q;
    case (op_q)
      owm_cmd_pkg::owm_op_reset: slot_req.kind = owm_bus_pkg::owm_slot_reset;
      owm_cmd_pkg::owm_op_write: slot_req.kind = shift_q[0] ? owm_bus_pkg::owm_slot_write1
                                                            : owm_bus_pkg::owm_slot_write0;
      default:                   slot_req.kind = owm_bus_pkg::owm_slot_read;
    endcase
  end

  assign rsp_in = '{op: op_q, line: line_q, data: shift_q, presence: presence_q};

  always_ff @(posedge MR or negedge CLK) begin
    if (!CLK) begin
      state_q   <= seq_idle;
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        seq_idle: if (next_valid) begin
          state_q   <= seq_request;
          bit_cnt_q <= '0;
        end
        seq_request: if (slot_ready) state_q <= seq_wait;
        seq_wait: if (slot_done) begin
          if (op_q == owm_cmd_pkg::owm_op_reset || bit_cnt_q == 3'd7) begin
            state_q <= seq_respond;
          end else begin
            state_q   <= seq_request;
            bit_cnt_q <= bit_cnt_q + 3'd1;
          end
        end
        default: if (rsp_in_ready) state_q <= seq_idle;
      endcase
    end
  end

  // Written bits leave from bit 0 while sampled bits enter at bit 7
  always_ff @(posedge MR) begin
    if (state_q == seq_idle && next_valid) begin
      op_q       <= next_cmd.op;
      line_q     <= next_cmd.line;
      shift_q    <= (next_cmd.op == owm_cmd_pkg::owm_op_reset) ? '0 : next_cmd.data;
      presence_q <= 1'b0;
    end else if (state_q == seq_wait && slot_done) begin
      if (op_q == owm_cmd_pkg::owm_op_reset) begin
        presence_q <= slot_bit;
      end else begin
        shift_q <= {slot_bit, shift_q[7:1]};
      end
    end
  end

endmodule

`default_nettype wire

//--- design/owm_cmd_intake.sv
`timescale 1ns/1ps
`default_nettype none

module owm_cmd_intake (
  input  wire                   MR,
  input  wire                   CLK,
  input  wire                   cmd_valid,
  input  owm_cmd_pkg::owm_cmd_t cmd,
  output logic                  cmd_ready,
  output logic                  next_valid,
  output owm_cmd_pkg::owm_cmd_t next_cmd,
  input  wire                   next_ready
);

  logic                  full_q;
  owm_cmd_pkg::owm_cmd_t entry_q;

  assign cmd_ready  = !full_q || next_ready; // Room now or entry leaves this cycle
  assign next_valid = full_q;
  assign next_cmd   = entry_q;

  always_ff @(posedge MR or negedge CLK) begin
    if (!CLK) begin
      full_q <= 1'b0;
    end else if (cmd_valid && cmd_ready) begin
      full_q <= 1'b1;
    end else if (next_ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge MR) begin
    if (cmd_valid && cmd_ready) begin
      entry_q <= cmd;
    end
  end

endmodule

`default_nettype wire

//--- design/owm_cmd_pkg.sv
`default_nettype none

package owm_cmd_pkg;

  typedef logic [7:0] owm_byte_t;

  typedef enum logic [1:0] {
    owm_op_reset = 2'd0,
    owm_op_write = 2'd1,
    owm_op_read  = 2'd2
  } owm_op_e;

  typedef struct packed {
    owm_op_e               op;
    owm_bus_pkg::owm_line_t line;
    owm_byte_t             data;
  } owm_cmd_t;

  // Write responses carry the read-back levels in data
  typedef struct packed {
    owm_op_e               op;
    owm_bus_pkg::owm_line_t line;
    owm_byte_t             data;
    logic                  presence;
  } owm_rsp_t;

endpackage

`default_nettype wire

//--- design/owm_bus_pkg.sv
`default_nettype none

package owm_bus_pkg;

  localparam int owm_num_lines = 8;

  typedef logic [2:0] owm_line_t;
  typedef logic [7:0] owm_tick_t;

  typedef enum logic [1:0] {
    owm_slot_reset  = 2'd0,
    owm_slot_write0 = 2'd1,
    owm_slot_write1 = 2'd2,
    owm_slot_read   = 2'd3
  } owm_slot_e;

  // Slot timing counts clock cycles and is scaled down for simulation
  localparam owm_tick_t owm_reset_low       = 8'd48;
  localparam owm_tick_t owm_presence_sample = 8'd60;
  localparam owm_tick_t owm_reset_total     = 8'd96;
  localparam owm_tick_t owm_write0_low      = 8'd12;
  localparam owm_tick_t owm_short_low       = 8'd2;
  localparam owm_tick_t owm_bit_sample      = 8'd6;
  localparam owm_tick_t owm_bit_total       = 8'd16;
  localparam int        owm_sync_stages     = 2;

  typedef struct packed {
    owm_slot_e kind;
    owm_line_t line;
  } owm_slot_req_t;

endpackage

`default_nettype wire
